//--- hw/cpu_params.sv
`default_nettype none

package cpu_params;

    localparam int XLEN     = 32;                 // Data and address width.
    localparam int ROB_IDX  = 5;                  // Width of a ROB id.

    localparam int CB_DEPTH = 8;                  // Outstanding branches.
    localparam int CB_IDX   = $clog2(CB_DEPTH);

    localparam int NUM_BRU  = 3;
    localparam int BRU_IDX  = 2;                  // Enough to index every unit.

endpackage

`default_nettype wire

//--- hw/uop_types.sv
`default_nettype none

package uop_types;

    import cpu_params::*;

    // Encodings follow the funct3 field of the conditional branches.
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_func_t;

    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    rs1_val;
        logic [XLEN-1:0]    rs2_val;
        br_func_t           func;
        logic               pred_taken;
        logic [XLEN-1:0]    pred_target;     // Only meaningful when pred_taken is set.
    } branch_uop_t;

    typedef struct packed {
        logic               valid;
        logic [ROB_IDX-1:0] rob_id;
        logic               miss_predict;
        logic [XLEN-1:0]    target_address;  // Actual next PC of the branch.
    } br_cdb_t;

    typedef struct packed {
        logic               head_valid;      // Non-empty and head resolved.
        logic [ROB_IDX-1:0] rob_id;
        logic               miss_predict;
        logic [XLEN-1:0]    target_address;
    } cb_rob_t;

endpackage

`default_nettype wire

//--- hw/branch_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module branch_dispatch (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ds_valid,
    input  uop_types::branch_uop_t              ds_uop,
    input  logic [cpu_params::NUM_BRU-1:0]      bru_busy,
    input  logic                                cb_full,
    output logic                                ds_ready,
    output logic [cpu_params::NUM_BRU-1:0]      issue_valid,
    output uop_types::branch_uop_t              issue_uop,
    output logic                                cb_enq,
    output logic [cpu_params::ROB_IDX-1:0]      cb_enq_rob_id
);

    import cpu_params::*;

    logic               free_found;
    logic [BRU_IDX-1:0] free_idx;
    logic               transfer;

    // Scanning downward leaves the lowest free unit selected.
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = NUM_BRU - 1; i >= 0; i--) begin
            if (!bru_busy[i]) begin
                free_found = 1'b1;
                free_idx   = BRU_IDX'(i);
            end
        end
    end

    assign ds_ready = free_found && !cb_full;
    assign transfer = ds_valid && ds_ready;

    always_comb begin
        issue_valid = '0;
        if (transfer) begin
            issue_valid[free_idx] = 1'b1;
        end
    end

    assign issue_uop     = ds_uop;
    assign cb_enq        = transfer;          // Buffer entry and unit issue share the cycle.
    assign cb_enq_rob_id = ds_uop.rob_id;

    issue_to_free_unit: assert property (@(posedge clk) disable iff (rst)
        $onehot0(issue_valid) && ((issue_valid & bru_busy) == '0))
        else $error("branch_dispatch: issue to a busy unit, issue=%b busy=%b",
                    issue_valid, bru_busy);

endmodule

`default_nettype wire

//--- hw/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  uop_types::branch_uop_t  issue_uop,
    input  logic                    grant,
    output logic                    busy,
    output logic                    result_valid,
    output uop_types::br_cdb_t      result
);

    import cpu_params::*;
    import uop_types::*;

    logic            taken;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] actual_next;
    logic [XLEN-1:0] pred_next;
    br_cdb_t         res_q;

    always_comb begin
        case (issue_uop.func)
            BR_BEQ:  taken = (issue_uop.rs1_val == issue_uop.rs2_val);
            BR_BNE:  taken = (issue_uop.rs1_val != issue_uop.rs2_val);
            BR_BLT:  taken = ($signed(issue_uop.rs1_val) < $signed(issue_uop.rs2_val));
            BR_BGE:  taken = ($signed(issue_uop.rs1_val) >= $signed(issue_uop.rs2_val));
            BR_BLTU: taken = (issue_uop.rs1_val < issue_uop.rs2_val);
            BR_BGEU: taken = (issue_uop.rs1_val >= issue_uop.rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4    = issue_uop.pc + XLEN'(4);
    assign actual_next = taken ? issue_uop.pc + issue_uop.imm : pc_plus4;
    assign pred_next   = issue_uop.pred_taken ? issue_uop.pred_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (issue_valid) begin
            result_valid <= 1'b1;
        end else if (grant) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res_q <= '{valid:          1'b1,
                       rob_id:         issue_uop.rob_id,
                       miss_predict:   (actual_next != pred_next),
                       target_address: actual_next};
        end
    end

    // A granted unit is free again in the same cycle.
    assign busy = result_valid && !grant;

    always_comb begin
        result       = res_q;
        result.valid = result_valid;
    end

    no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !busy)
        else $error("branch_unit: issue while busy");

    held_until_grant: assert property (@(posedge clk) disable iff (rst)
        result_valid && !grant |=> result_valid && $stable(res_q))
        else $error("branch_unit: result dropped or changed before grant");

endmodule

`default_nettype wire

//--- hw/branch_cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module branch_cdb_arbiter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cpu_params::NUM_BRU-1:0]  result_valid,
    input  uop_types::br_cdb_t              results [cpu_params::NUM_BRU],
    output logic [cpu_params::NUM_BRU-1:0]  grant,
    output uop_types::br_cdb_t              br_cdb
);

    import cpu_params::*;
    import uop_types::*;

    logic [BRU_IDX-1:0] last;                  // Most recent grantee.
    logic [BRU_IDX-1:0] sel;
    logic               found;
    logic               cdb_valid;
    br_cdb_t            cdb_q;

    // Search starts one past the last grantee and wraps around.
    always_comb begin
        int cand;
        found = 1'b0;
        sel   = '0;
        grant = '0;
        for (int i = 1; i <= NUM_BRU; i++) begin
            cand = (int'(last) + i) % NUM_BRU;
            if (!found && result_valid[cand]) begin
                found = 1'b1;
                sel   = BRU_IDX'(cand);
            end
        end
        if (found) begin
            grant[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
            last      <= BRU_IDX'(NUM_BRU - 1);  // Unit 0 wins first.
        end else begin
            cdb_valid <= found;
            if (found) begin
                last <= sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            cdb_q <= results[sel];
        end
    end

    always_comb begin
        br_cdb       = cdb_q;
        br_cdb.valid = cdb_valid;            // Valid for exactly one cycle per grant.
    end

    grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant))
        else $error("branch_cdb_arbiter: more than one grant, grant=%b", grant);

endmodule

`default_nettype wire

//--- hw/control_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module control_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cb_enq,
    input  logic [cpu_params::ROB_IDX-1:0]  cb_enq_rob_id,
    input  uop_types::br_cdb_t              br_cdb,
    input  logic                            rob_dequeue,
    output logic                            cb_full,
    output uop_types::cb_rob_t              cb_head
);

    import cpu_params::*;

    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic               miss_predict;
        logic [XLEN-1:0]    target_address;
        logic               resolved;
    } cb_entry_t;

    cb_entry_t           fifo [CB_DEPTH];

    logic [CB_IDX:0]     wr_ptr;              // Top bit is the wrap flag.
    logic [CB_IDX:0]     rd_ptr;
    logic [CB_IDX-1:0]   wr_idx;
    logic [CB_IDX-1:0]   rd_idx;
    logic [CB_IDX:0]     count;
    logic                empty;
    logic [CB_DEPTH-1:0] occupied;
    logic [CB_DEPTH-1:0] match;

    assign wr_idx  = wr_ptr[CB_IDX-1:0];
    assign rd_idx  = rd_ptr[CB_IDX-1:0];
    assign count   = wr_ptr - rd_ptr;
    assign empty   = (wr_ptr == rd_ptr);
    assign cb_full = (wr_idx == rd_idx) && (wr_ptr[CB_IDX] != rd_ptr[CB_IDX]);

    // An entry is live when its distance from the head is below the count.
    always_comb begin
        for (int i = 0; i < CB_DEPTH; i++) begin
            occupied[i] = {1'b0, CB_IDX'(CB_IDX'(i) - rd_idx)} < count;
            match[i]    = occupied[i] && (fifo[i].rob_id == br_cdb.rob_id);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (cb_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rob_dequeue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cb_enq) begin
            fifo[wr_idx].rob_id   <= cb_enq_rob_id;
            fifo[wr_idx].resolved <= 1'b0;
        end
        if (br_cdb.valid) begin
            for (int i = 0; i < CB_DEPTH; i++) begin
                if (match[i]) begin
                    fifo[i].resolved       <= 1'b1;
                    fifo[i].miss_predict   <= br_cdb.miss_predict;
                    fifo[i].target_address <= br_cdb.target_address;
                end
            end
        end
    end

    always_comb begin
        cb_head.head_valid     = !empty && fifo[rd_idx].resolved;
        cb_head.rob_id         = fifo[rd_idx].rob_id;
        cb_head.miss_predict   = fifo[rd_idx].miss_predict;
        cb_head.target_address = fifo[rd_idx].target_address;
    end

    deq_needs_head: assert property (@(posedge clk) disable iff (rst)
        rob_dequeue |-> cb_head.head_valid)
        else $error("control_buffer: dequeue while head not valid");

    no_enq_when_full: assert property (@(posedge clk) disable iff (rst)
        cb_enq |-> !cb_full)
        else $error("control_buffer: enqueue while full");

    // Every bus result belongs to exactly one outstanding branch.
    result_hits_one: assert property (@(posedge clk) disable iff (rst)
        br_cdb.valid |-> $onehot(match))
        else $error("control_buffer: result rob_id %0d matched %b",
                    br_cdb.rob_id, match);

endmodule

`default_nettype wire

//--- hw/branch_resolve_top.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ds_valid,
    input  uop_types::branch_uop_t  ds_uop,
    input  logic                    rob_dequeue,
    output logic                    ds_ready,
    output uop_types::br_cdb_t      br_cdb,
    output uop_types::cb_rob_t      cb_head
);

    import cpu_params::*;
    import uop_types::*;

    logic [NUM_BRU-1:0] bru_busy;
    logic [NUM_BRU-1:0] issue_valid;
    logic [NUM_BRU-1:0] result_valid;
    logic [NUM_BRU-1:0] grant;
    branch_uop_t        issue_uop;
    br_cdb_t            bru_result [NUM_BRU];
    logic               cb_full;
    logic               cb_enq;
    logic [ROB_IDX-1:0] cb_enq_rob_id;

    branch_dispatch u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .ds_valid      (ds_valid),
        .ds_uop        (ds_uop),
        .bru_busy      (bru_busy),
        .cb_full       (cb_full),
        .ds_ready      (ds_ready),
        .issue_valid   (issue_valid),
        .issue_uop     (issue_uop),
        .cb_enq        (cb_enq),
        .cb_enq_rob_id (cb_enq_rob_id)
    );

    for (genvar k = 0; k < NUM_BRU; k++) begin : g_bru
        branch_unit u_bru (
            .clk          (clk),
            .rst          (rst),
            .issue_valid  (issue_valid[k]),
            .issue_uop    (issue_uop),
            .grant        (grant[k]),
            .busy         (bru_busy[k]),
            .result_valid (result_valid[k]),
            .result       (bru_result[k])
        );
    end

    branch_cdb_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .result_valid (result_valid),
        .results      (bru_result),
        .grant        (grant),
        .br_cdb       (br_cdb)
    );

    control_buffer u_cb (
        .clk           (clk),
        .rst           (rst),
        .cb_enq        (cb_enq),
        .cb_enq_rob_id (cb_enq_rob_id),
        .br_cdb        (br_cdb),
        .rob_dequeue   (rob_dequeue),
        .cb_full       (cb_full),
        .cb_head       (cb_head)
    );

endmodule

`default_nettype wire

//--- sim/tb_branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_resolve;

    import cpu_params::*;
    import uop_types::*;

    logic        clk;
    logic        rst;
    logic        ds_valid;
    branch_uop_t ds_uop;
    logic        rob_dequeue;
    logic        ds_ready;
    br_cdb_t     br_cdb;
    cb_rob_t     cb_head;

    integer seed = 32'hd0d4;
    int     errors = 0;
    int     acc_count = 0;
    int     deq_count = 0;
    int     bus_count = 0;
    int     out_count = 0;
    int     wait_cycles;
    int     acc_before;
    logic   timed_out = 1'b0;
    logic   post_reset = 1'b0;
    logic   want_valid = 1'b0;
    logic   stall = 1'b0;
    logic   auto_stall = 1'b0;
    logic   last_xfer = 1'b0;

    branch_uop_t              cur_uop;
    logic [ROB_IDX-1:0]       next_id;
    br_cdb_t                  exp_q [$];
    br_cdb_t                  exp_front;
    logic [(1<<ROB_IDX)-1:0]  out_m;
    logic [(1<<ROB_IDX)-1:0]  seen_m;
    logic [(1<<ROB_IDX)-1:0]  out_mask;
    logic [(1<<ROB_IDX)-1:0]  seen_mask;

    branch_resolve_top DUT (
        .clk         (clk),
        .rst         (rst),
        .ds_valid    (ds_valid),
        .ds_uop      (ds_uop),
        .rob_dequeue (rob_dequeue),
        .ds_ready    (ds_ready),
        .br_cdb      (br_cdb),
        .cb_head     (cb_head)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // A small operand set makes equal and signed/unsigned edge cases common.
    function automatic logic [XLEN-1:0] pick_operand();
        case ($unsigned($random(seed)) % 5)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'h0000_0007;
        endcase
    endfunction

    function automatic branch_uop_t random_uop(input logic [ROB_IDX-1:0] id);
        branch_uop_t u;
        u.rob_id  = id;
        u.pc      = $random(seed) & 32'hffff_fffc;
        u.imm     = $random(seed) & 32'h0000_1ffc;
        u.rs1_val = pick_operand();
        u.rs2_val = pick_operand();
        case ($unsigned($random(seed)) % 6)
            0:       u.func = BR_BEQ;
            1:       u.func = BR_BNE;
            2:       u.func = BR_BLT;
            3:       u.func = BR_BGE;
            4:       u.func = BR_BLTU;
            default: u.func = BR_BGEU;
        endcase
        u.pred_taken = ($random(seed) & 1) != 0;
        if ($random(seed) & 1) begin
            u.pred_target = u.pc + u.imm;        // A correct taken guess.
        end else begin
            u.pred_target = $random(seed);
        end
        return u;
    endfunction

    function automatic br_cdb_t branch_outcome(input branch_uop_t u);
        logic            taken;
        logic [XLEN-1:0] next_pc;
        logic [XLEN-1:0] pred_pc;
        br_cdb_t         r;
        case (u.func)
            BR_BEQ:  taken = (u.rs1_val == u.rs2_val);
            BR_BNE:  taken = (u.rs1_val != u.rs2_val);
            BR_BLT:  taken = ($signed(u.rs1_val) < $signed(u.rs2_val));
            BR_BGE:  taken = ($signed(u.rs1_val) >= $signed(u.rs2_val));
            BR_BLTU: taken = (u.rs1_val < u.rs2_val);
            BR_BGEU: taken = (u.rs1_val >= u.rs2_val);
            default: taken = 1'b0;
        endcase
        next_pc          = taken ? u.pc + u.imm : u.pc + 32'd4;
        pred_pc          = u.pred_taken ? u.pred_target : u.pc + 32'd4;
        r.valid          = 1'b1;
        r.rob_id         = u.rob_id;
        r.miss_predict   = (next_pc != pred_pc);
        r.target_address = next_pc;
        return r;
    endfunction

    task automatic drive_cycle();
        @(negedge clk);
        if (last_xfer) begin
            cur_uop = random_uop(next_id);
            next_id = next_id + 1'b1;
        end
        if (auto_stall && (($random(seed) & 31) == 0)) begin
            stall = !stall;
        end
        ds_uop      = cur_uop;
        ds_valid    = want_valid && (($random(seed) & 3) != 0);
        rob_dequeue = cb_head.head_valid && !stall && (($random(seed) & 1) == 0);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            out_m     = '0;
            seen_m    = '0;
            last_xfer = 1'b0;
        end else begin
            if (rob_dequeue && exp_q.size() > 0) begin
                out_m[exp_q[0].rob_id]  = 1'b0;
                seen_m[exp_q[0].rob_id] = 1'b0;
                void'(exp_q.pop_front());
                deq_count = deq_count + 1;
            end
            if (br_cdb.valid) begin
                seen_m[br_cdb.rob_id] = 1'b1;
                bus_count = bus_count + 1;
            end
            last_xfer = ds_valid && ds_ready;
            if (last_xfer) begin
                exp_q.push_back(branch_outcome(ds_uop));
                out_m[ds_uop.rob_id] = 1'b1;
                acc_count = acc_count + 1;
            end
        end
        out_mask  <= out_m;
        seen_mask <= seen_m;
        out_count <= exp_q.size();
        exp_front <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    reset_idle: assert property (@(posedge clk) disable iff (rst)
        post_reset |-> ds_ready && !cb_head.head_valid && !br_cdb.valid)
        else begin
            errors = errors + 1;
            $display("mismatch reset_idle: expected ready=1 head=0 cdb=0, actual %b %b %b",
                     ds_ready, cb_head.head_valid, br_cdb.valid);
        end

    deq_outstanding: assert property (@(posedge clk) disable iff (rst)
        rob_dequeue |-> out_count != 0)
        else begin
            errors = errors + 1;
            $display("head offered for dequeue while no branch was outstanding");
        end

    head_rob_id: assert property (@(posedge clk) disable iff (rst)
        rob_dequeue && out_count != 0 |-> cb_head.rob_id == exp_front.rob_id)
        else begin
            errors = errors + 1;
            $display("mismatch head_rob_id: expected %0d, actual %0d",
                     exp_front.rob_id, cb_head.rob_id);
        end

    head_miss: assert property (@(posedge clk) disable iff (rst)
        rob_dequeue && out_count != 0 |-> cb_head.miss_predict == exp_front.miss_predict)
        else begin
            errors = errors + 1;
            $display("mismatch head_miss: expected %b, actual %b",
                     exp_front.miss_predict, cb_head.miss_predict);
        end

    head_target: assert property (@(posedge clk) disable iff (rst)
        rob_dequeue && out_count != 0 |-> cb_head.target_address == exp_front.target_address)
        else begin
            errors = errors + 1;
            $display("mismatch head_target: expected %h, actual %h",
                     exp_front.target_address, cb_head.target_address);
        end

    head_was_on_bus: assert property (@(posedge clk) disable iff (rst)
        rob_dequeue |-> seen_mask[cb_head.rob_id])
        else begin
            errors = errors + 1;
            $display("rob id %0d was dequeued without a result on the bus", cb_head.rob_id);
        end

    cdb_outstanding: assert property (@(posedge clk) disable iff (rst)
        br_cdb.valid |-> out_mask[br_cdb.rob_id])
        else begin
            errors = errors + 1;
            $display("bus result for rob id %0d, which is not outstanding", br_cdb.rob_id);
        end

    cdb_once: assert property (@(posedge clk) disable iff (rst)
        br_cdb.valid |-> !seen_mask[br_cdb.rob_id])
        else begin
            errors = errors + 1;
            $display("bus carried rob id %0d a second time", br_cdb.rob_id);
        end

    full_blocks: assert property (@(posedge clk) disable iff (rst)
        out_count >= CB_DEPTH |-> !ds_ready && out_count == CB_DEPTH)
        else begin
            errors = errors + 1;
            $display("mismatch full_blocks: expected ready=0 count=%0d, actual ready=%b count=%0d",
                     CB_DEPTH, ds_ready, out_count);
        end

    initial begin
        rst         = 1'b1;
        ds_valid    = 1'b0;
        rob_dequeue = 1'b0;
        cur_uop     = random_uop('0);
        next_id     = 1;
        ds_uop      = cur_uop;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst        = 1'b0;
        post_reset = 1'b1;
        repeat (2) drive_cycle();
        @(negedge clk);
        post_reset = 1'b0;

        // Random traffic with the ROB stalling now and then.
        want_valid  = 1'b1;
        auto_stall  = 1'b1;
        wait_cycles = 0;
        while (acc_count < 200 && !timed_out) begin
            drive_cycle();
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 20000) begin
                timed_out = 1'b1;
                $display("timeout: random traffic accepted only %0d branches", acc_count);
            end
        end

        // ROB held off until the buffer fills.
        auto_stall  = 1'b0;
        stall       = 1'b1;
        wait_cycles = 0;
        while (out_count < CB_DEPTH && !timed_out) begin
            drive_cycle();
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 200) begin
                timed_out = 1'b1;
                $display("timeout: control buffer never filled under a stalled ROB");
            end
        end
        repeat (10) drive_cycle();

        stall       = 1'b0;
        acc_before  = acc_count;
        wait_cycles = 0;
        while (acc_count == acc_before && !timed_out) begin
            drive_cycle();
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 100) begin
                timed_out = 1'b1;
                $display("timeout: dispatch did not resume after the ROB dequeued");
            end
        end

        want_valid  = 1'b0;
        wait_cycles = 0;
        while (out_count != 0 && !timed_out) begin
            drive_cycle();
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 500) begin
                timed_out = 1'b1;
                $display("timeout: %0d branches still outstanding at drain", out_count);
            end
        end
        repeat (2) drive_cycle();

        all_on_bus: assert (timed_out || bus_count == acc_count)
            else begin
                errors = errors + 1;
                $display("mismatch all_on_bus: expected %0d, actual %0d", acc_count, bus_count);
            end

        $display("errors=%0d accepted=%0d dequeued=%0d bus_results=%0d",
                 errors, acc_count, deq_count, bus_count);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/cpu_params.sv
hw/uop_types.sv
hw/branch_dispatch.sv
hw/branch_unit.sv
hw/branch_cdb_arbiter.sv
hw/control_buffer.sv
hw/branch_resolve_top.sv
sim/tb_branch_resolve.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the branch resolution testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_branch_resolve \
    -f filelist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
